// File: ballSeeker.f
src/ballSeekerPkg.sv
src/directionControl.sv
src/dualPwm.sv
src/apbConfig.sv
src/ballSeekerTop.sv
tests/ballSeekerChecker.sv
tests/ballSeekerTb.sv

// File: src/apbConfig.sv
// ############################
// APB register block for the drive controller
// Holds enable, duty table and reverse length
// Zero wait states, unmapped offsets answer with pslverr
// ############################

`timescale 1ns/100ps

module apbConfig #(
    parameter int revCountWidth = 16
) (
    input  logic                       clk,
    input  logic                       arstN,
    input  ballSeekerPkg::apbReq_t     apbReq,
    output ballSeekerPkg::apbRsp_t     apbRsp,
    input  ballSeekerPkg::driveState_t state,
    input  logic                       done,
    output logic                       runEnable,
    output ballSeekerPkg::dutyTable_t  dutyTable,
    output logic [revCountWidth-1:0]   revLen
);

    import ballSeekerPkg::*;

    regAddr_t    addr;
    logic        access;
    logic        addrHit;
    logic        wrEn;
    logic        rdEn;
    logic [31:0] readData;

    assign addr   = regAddr_t'(apbReq.paddr);
    // Access phase of a transfer
    assign access = apbReq.psel & apbReq.penable;

    // ##########################
    // Address decode and read mux
    // ##########################
    always_comb begin
        addrHit  = 1'b1;
        readData = '0;
        case (addr)
            CTRL:    readData = {31'b0, runEnable};
            DUTY:    readData = dutyTable;
            REVLEN:  readData = 32'(revLen);
            STATUS:  readData = {28'b0, done, state};
            default: addrHit = 1'b0;
        endcase
    end

    assign wrEn = access & apbReq.pwrite & addrHit;
    assign rdEn = access & ~apbReq.pwrite & addrHit;

    assign apbRsp.prdata  = rdEn ? readData : '0;
    assign apbRsp.pready  = 1'b1;
    assign apbRsp.pslverr = access & ~addrHit;

    // ##########################
    // Writable registers
    // ##########################
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            runEnable <= 1'b0;
            dutyTable <= '0;
            revLen    <= '0;
        end else if (wrEn) begin
            case (addr)
                CTRL:   runEnable <= apbReq.pwdata[0];
                DUTY:   dutyTable <= dutyTable_t'(apbReq.pwdata);
                REVLEN: revLen    <= apbReq.pwdata[revCountWidth-1:0];
                // STATUS is read-only, writes are dropped
                default: ;
            endcase
        end
    end

endmodule

// File: src/ballSeekerPkg.sv
// ############################
// Shared types for the ball-seeking drive controller
// Import into a module body with a wildcard import
// Module headers refer to the types by scoped name
// ############################

package ballSeekerPkg;

    // Drive FSM states
    typedef enum logic [2:0] {
        IDLE,
        PAUSE,
        REVERSE,
        TURN_RIGHT,
        TURN_LEFT
    } driveState_t;

    // APB register offsets
    typedef enum logic [3:0] {
        CTRL   = 4'h0,
        DUTY   = 4'h4,
        REVLEN = 4'h8,
        STATUS = 4'hC
    } regAddr_t;

    // Host to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apbReq_t;

    // Slave to host
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp_t;

    typedef struct packed {
        logic pause;
        logic wireSeen;
        logic ballCaught;
        // 1 when the right microphone hears the ball first
        logic ballRight;
    } sensorIn_t;

    typedef struct packed {
        logic       fwdA;
        logic       fwdB;
        logic       bwdA;
        logic       bwdB;
        logic [1:0] dutySelA;
        logic [1:0] dutySelB;
    } motorCmd_t;

    // Direction lines after PWM gating
    typedef struct packed {
        logic fwdA;
        logic bwdA;
        logic fwdB;
        logic bwdB;
    } motorDrive_t;

    // Level 0 sits in the lowest byte
    typedef struct packed {
        logic [3:0][7:0] level;
    } dutyTable_t;

endpackage

// File: src/ballSeekerTop.sv
// ############################
// Top level of the ball-seeking drive controller
// APB host port in, gated motor direction lines out
// ############################

`timescale 1ns/100ps

module ballSeekerTop #(
    parameter int pwmWidth      = 8,
    parameter int revCountWidth = 16
) (
    input  logic                       clk,
    input  logic                       arstN,
    input  ballSeekerPkg::apbReq_t     apbReq,
    output ballSeekerPkg::apbRsp_t     apbRsp,
    input  ballSeekerPkg::sensorIn_t   sensors,
    output ballSeekerPkg::motorDrive_t drive,
    output logic                       done
);

    import ballSeekerPkg::*;

    logic                     runEnable;
    dutyTable_t               dutyTable;
    logic [revCountWidth-1:0] revLen;
    driveState_t              state;
    motorCmd_t                cmd;
    logic                     pwmA;
    logic                     pwmB;

    apbConfig #(
        .revCountWidth(revCountWidth)
    ) uApbConfig (
        .clk      (clk),
        .arstN    (arstN),
        .apbReq   (apbReq),
        .apbRsp   (apbRsp),
        .state    (state),
        .done     (done),
        .runEnable(runEnable),
        .dutyTable(dutyTable),
        .revLen   (revLen)
    );

    directionControl #(
        .revCountWidth(revCountWidth)
    ) uDirectionControl (
        .clk      (clk),
        .arstN    (arstN),
        .runEnable(runEnable),
        .sensors  (sensors),
        .revLen   (revLen),
        .cmd      (cmd),
        .state    (state),
        .done     (done)
    );

    dualPwm #(
        .pwmWidth(pwmWidth)
    ) uDualPwm (
        .clk      (clk),
        .arstN    (arstN),
        .dutySelA (cmd.dutySelA),
        .dutySelB (cmd.dutySelB),
        .dutyTable(dutyTable),
        .pwmA     (pwmA),
        .pwmB     (pwmB)
    );

    // Each side's direction lines only see that side's pulse
    assign drive.fwdA = cmd.fwdA & pwmA;
    assign drive.bwdA = cmd.bwdA & pwmA;
    assign drive.fwdB = cmd.fwdB & pwmB;
    assign drive.bwdB = cmd.bwdB & pwmB;

endmodule

// File: src/directionControl.sv
// ############################
// Direction FSM for the ball-seeking robot
// Samples the sensors each edge and registers the new state
// together with its motor command and done flag
// ############################

`timescale 1ns/100ps

module directionControl #(
    parameter int revCountWidth = 16
) (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       runEnable,
    input  ballSeekerPkg::sensorIn_t   sensors,
    input  logic [revCountWidth-1:0]   revLen,
    output ballSeekerPkg::motorCmd_t   cmd,
    output ballSeekerPkg::driveState_t state,
    output logic                       done
);

    import ballSeekerPkg::*;

    driveState_t              nextState;
    driveState_t              prevTurn;
    logic [revCountWidth-1:0] revCount;
    logic                     revDone;
    motorCmd_t                nextCmd;
    logic                     nextDone;

    // Minimum reverse time has elapsed
    assign revDone = (revCount >= revLen);

    // ##########################
    // Next-state logic
    // ##########################
    always_comb begin
        nextState = state;
        if (sensors.ballCaught) begin
            // Ball in the catcher ends the run from any state
            nextState = IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (runEnable) begin
                        nextState = TURN_RIGHT;
                    end
                end
                PAUSE: begin
                    if (!sensors.pause) begin
                        nextState = prevTurn;
                    end
                end
                REVERSE: begin
                    // Keep backing up while the wire is still under the robot
                    if (revDone && !sensors.wireSeen) begin
                        nextState = prevTurn;
                    end
                end
                TURN_RIGHT, TURN_LEFT: begin
                    if (sensors.pause) begin
                        nextState = PAUSE;
                    end else if (sensors.wireSeen) begin
                        nextState = REVERSE;
                    end else if (sensors.ballRight) begin
                        nextState = TURN_RIGHT;
                    end else begin
                        nextState = TURN_LEFT;
                    end
                end
                default: nextState = IDLE;
            endcase
        end
    end

    // Command decode from the next state so it lands with the state
    always_comb begin
        nextCmd  = '0;
        nextDone = 1'b0;
        case (nextState)
            IDLE: nextDone = 1'b1;
            REVERSE: begin
                nextCmd.bwdA     = 1'b1;
                nextCmd.bwdB     = 1'b1;
                nextCmd.dutySelA = 2'd3;
                nextCmd.dutySelB = 2'd3;
            end
            TURN_RIGHT: begin
                nextCmd.fwdA     = 1'b1;
                nextCmd.fwdB     = 1'b1;
                nextCmd.dutySelA = 2'd2;
            end
            TURN_LEFT: begin
                nextCmd.fwdA     = 1'b1;
                nextCmd.fwdB     = 1'b1;
                nextCmd.dutySelB = 2'd2;
            end
            // PAUSE leaves both motors off
            default: nextDone = 1'b0;
        endcase
    end

    // ##########################
    // State, command and turn memory
    // ##########################
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= IDLE;
            prevTurn <= TURN_RIGHT;
            cmd      <= '0;
            done     <= 1'b1;
        end else begin
            state <= nextState;
            cmd   <= nextCmd;
            done  <= nextDone;
            if (state == TURN_RIGHT || state == TURN_LEFT) begin
                prevTurn <= state;
            end
        end
    end

    // Reverse duration counter, 1 in the first REVERSE cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            revCount <= '0;
        end else if (nextState == REVERSE && state != REVERSE) begin
            revCount <= revCountWidth'(1);
        end else if (state == REVERSE && revCount != '1) begin
            // saturates instead of wrapping on very long wire crossings
            revCount <= revCount + 1'b1;
        end
    end

endmodule

// File: src/dualPwm.sv
// ############################
// Two-channel PWM for the A and B motors
// One shared period counter, each side compared against
// its selected duty level with a registered output
// ############################

`timescale 1ns/100ps

module dualPwm #(
    parameter int pwmWidth = 8
) (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic [1:0]                dutySelA,
    input  logic [1:0]                dutySelB,
    input  ballSeekerPkg::dutyTable_t dutyTable,
    output logic                      pwmA,
    output logic                      pwmB
);

    import ballSeekerPkg::*;

    logic [pwmWidth-1:0] periodCnt;
    logic [pwmWidth-1:0] levelA;
    logic [pwmWidth-1:0] levelB;

    // Table levels truncated to the counter width
    assign levelA = dutyTable.level[dutySelA][pwmWidth-1:0];
    assign levelB = dutyTable.level[dutySelB][pwmWidth-1:0];

    // Free-running period counter, wraps naturally
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            periodCnt <= '0;
        end else begin
            periodCnt <= periodCnt + 1'b1;
        end
    end

    // Level 0 never pulses, full scale is high all but one count
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pwmA <= 1'b0;
            pwmB <= 1'b0;
        end else begin
            pwmA <= (periodCnt < levelA);
            pwmB <= (periodCnt < levelB);
        end
    end

endmodule

// File: tests/ballSeekerChecker.sv
// ############################
// Reference model and scoreboard for the drive controller
// Mirrors APB writes, predicts FSM and PWM cycle by cycle
// and compares drive, done and APB responses at each edge
// ############################

`timescale 1ns/100ps

module ballSeekerChecker #(
    parameter int pwmWidth      = 4,
    parameter int revCountWidth = 16
) (
    input logic                       clk,
    input logic                       arstN,
    input ballSeekerPkg::apbReq_t     apbReq,
    input ballSeekerPkg::apbRsp_t     apbRsp,
    input ballSeekerPkg::sensorIn_t   sensors,
    input ballSeekerPkg::motorDrive_t drive,
    input logic                       done
);

    import ballSeekerPkg::*;

    int                       errorCount = 0;
    logic                     runEn;
    logic [7:0]               level [4];
    logic [revCountWidth-1:0] revLen;
    logic [revCountWidth-1:0] revCnt;
    driveState_t              st;
    driveState_t              prevTurn;
    driveState_t              nextSt;
    logic [pwmWidth-1:0]      cnt;
    logic                     pwmA;
    logic                     pwmB;
    logic [1:0]               selA;
    logic [1:0]               selB;
    logic                     turning;
    motorDrive_t              expDrive;
    logic [31:0]              expData;
    logic                     mapped;

    // ##########################
    // Model of the transition rules and command table
    // ##########################
    always_comb begin
        turning = (st == TURN_RIGHT) || (st == TURN_LEFT);
        nextSt  = st;
        if (sensors.ballCaught) nextSt = IDLE;
        else if (st == IDLE && runEn) nextSt = TURN_RIGHT;
        else if (st == PAUSE && !sensors.pause) nextSt = prevTurn;
        else if (st == REVERSE && revCnt >= revLen && !sensors.wireSeen) nextSt = prevTurn;
        else if (turning) begin
            if (sensors.pause) nextSt = PAUSE;
            else if (sensors.wireSeen) nextSt = REVERSE;
            else nextSt = sensors.ballRight ? TURN_RIGHT : TURN_LEFT;
        end
        selA = (st == REVERSE) ? 2'd3 : ((st == TURN_RIGHT) ? 2'd2 : 2'd0);
        selB = (st == REVERSE) ? 2'd3 : ((st == TURN_LEFT) ? 2'd2 : 2'd0);
        expDrive.fwdA = turning & pwmA;
        expDrive.fwdB = turning & pwmB;
        expDrive.bwdA = (st == REVERSE) & pwmA;
        expDrive.bwdB = (st == REVERSE) & pwmB;
        // Expected register read data
        mapped  = 1'b1;
        expData = '0;
        case (apbReq.paddr)
            4'h0: expData = {31'b0, runEn};
            4'h4: expData = {level[3], level[2], level[1], level[0]};
            4'h8: expData = 32'(revLen);
            4'hC: expData = {28'b0, (st == IDLE), st};
            default: mapped = 1'b0;
        endcase
    end

    // Compare against the pre-edge model, then advance it
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            runEn    <= 1'b0;
            revLen   <= '0;
            revCnt   <= '0;
            st       <= IDLE;
            prevTurn <= TURN_RIGHT;
            cnt      <= '0;
            pwmA     <= 1'b0;
            pwmB     <= 1'b0;
            for (int i = 0; i < 4; i++) level[i] <= '0;
        end else begin
            if (drive !== expDrive || done !== (st == IDLE)) begin
                errorCount++;
                $display("MISMATCH at %0t: drive %b done %b, expected drive %b done %b",
                         $time, drive, done, expDrive, (st == IDLE));
            end
            if (apbReq.psel && apbReq.penable) begin
                if (apbRsp.pslverr !== !mapped || apbRsp.pready !== 1'b1) begin
                    errorCount++;
                    $display("MISMATCH at %0t: addr %h pslverr %b pready %b", $time,
                             apbReq.paddr, apbRsp.pslverr, apbRsp.pready);
                end
                if (!apbReq.pwrite && apbRsp.prdata !== expData) begin
                    errorCount++;
                    $display("MISMATCH at %0t: read addr %h got %h, expected %h", $time,
                             apbReq.paddr, apbRsp.prdata, expData);
                end
                if (apbReq.pwrite) begin
                    case (apbReq.paddr)
                        4'h0: runEn <= apbReq.pwdata[0];
                        4'h4: for (int i = 0; i < 4; i++) level[i] <= apbReq.pwdata[8*i +: 8];
                        4'h8: revLen <= apbReq.pwdata[revCountWidth-1:0];
                        default: ;
                    endcase
                end
            end
            st <= nextSt;
            if (turning) prevTurn <= st;
            if (nextSt == REVERSE && st != REVERSE) revCnt <= revCountWidth'(1);
            else if (st == REVERSE) revCnt <= revCnt + 1'b1;
            cnt  <= cnt + 1'b1;
            pwmA <= (cnt < level[selA][pwmWidth-1:0]);
            pwmB <= (cnt < level[selB][pwmWidth-1:0]);
        end
    end

endmodule

// File: tests/ballSeekerTb.sv
// ############################
// Testbench top for the drive controller
// Clock, reset, APB transfers and random sensor stimulus
// Checking is done by the checker module
// ############################

`timescale 1ns/100ps

module ballSeekerTb;

    import ballSeekerPkg::*;

    localparam int pwmWidth      = 4;
    localparam int revCountWidth = 16;
    // Worst-case length of all tests, plus a margin
    localparam int plannedCycles = 420;
    localparam int cycleLimit    = plannedCycles + 80;

    logic        clk;
    logic        arstN;
    apbReq_t     apbReq;
    apbRsp_t     apbRsp;
    sensorIn_t   sensors;
    motorDrive_t drive;
    logic        done;
    sensorIn_t   stim;
    integer      seed = 74;
    int          tbErrors = 0;
    int          errorsBefore = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    int          cycleCount = 0;

    ballSeekerTop #(.pwmWidth(pwmWidth), .revCountWidth(revCountWidth)) DUT (
        .clk(clk), .arstN(arstN), .apbReq(apbReq), .apbRsp(apbRsp),
        .sensors(sensors), .drive(drive), .done(done)
    );

    ballSeekerChecker #(.pwmWidth(pwmWidth), .revCountWidth(revCountWidth)) uChecker (
        .clk(clk), .arstN(arstN), .apbReq(apbReq), .apbRsp(apbRsp),
        .sensors(sensors), .drive(drive), .done(done)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic int randomRange(input int lo, input int hi);
        return lo + ($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Setup and access cycle, each task returns on a falling edge
    task automatic apbTransfer(input logic wr, input logic [3:0] addr, input logic [31:0] data);
        apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
        @(negedge clk);
        apbReq.penable = 1'b1;
        @(negedge clk);
        apbReq = '0;
    endtask

    task automatic holdSensors(input sensorIn_t value, input int cycles);
        sensors = value;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic waitForDone(input int maxCycles);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done && waited < maxCycles) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            tbErrors++;
            $display("Machine did not return to IDLE within %0d cycles at %0t", maxCycles, $time);
        end
    endtask

    task automatic finishTest(input string name);
        int errs;
        @(negedge clk);
        errs = uChecker.errorCount + tbErrors - errorsBefore;
        errorsBefore = uChecker.errorCount + tbErrors;
        if (errs == 0) testsPassed++;
        else testsFailed++;
        $display("Test %0s: %0s (%0d errors)", name, (errs == 0) ? "ok" : "failing", errs);
    endtask

    // Watchdog
    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run timed out after %0d cycles without finishing the tests", cycleCount);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        arstN   = 1'b0;
        apbReq  = '0;
        sensors = '0;
        repeat (5) @(negedge clk);
        arstN = 1'b1;

        // Register access
        apbTransfer(1'b1, 4'h4, {8'd15, 8'd9, 8'd3, 8'd0});
        apbTransfer(1'b1, 4'h8, 32'd6);
        apbTransfer(1'b0, 4'h4, '0);
        apbTransfer(1'b0, 4'h8, '0);
        apbTransfer(1'b0, 4'hC, '0);
        apbTransfer(1'b0, 4'h2, '0);
        finishTest("register access");

        // Idle with random sensors, then start
        repeat (8) begin
            stim = sensorIn_t'(randomRange(0, 15));
            stim.ballCaught = 1'b0;
            holdSensors(stim, randomRange(1, 5));
        end
        sensors = '0;
        apbTransfer(1'b1, 4'h0, 32'd1);
        @(negedge clk);
        if (done !== 1'b0) begin
            tbErrors++;
            $display("MISMATCH at %0t: done still high one edge after enable", $time);
        end
        holdSensors('0, 2);
        finishTest("idle and start");

        // Steering
        repeat (12) begin
            stim = '0;
            stim.ballRight = randomRange(0, 1);
            holdSensors(stim, randomRange(1, 8));
        end
        finishTest("steering and PWM");

        // Pause during a turn
        repeat (5) begin
            stim = '0;
            stim.ballRight = randomRange(0, 1);
            holdSensors(stim, randomRange(1, 6));
            stim.pause = 1'b1;
            holdSensors(stim, randomRange(1, 6));
            stim.pause = 1'b0;
            holdSensors(stim, 3);
        end
        finishTest("pause");

        // Boundary wire crossings
        repeat (4) begin
            stim = '0;
            stim.wireSeen = 1'b1;
            stim.ballRight = randomRange(0, 1);
            holdSensors(stim, randomRange(1, 12));
            stim.wireSeen = 1'b0;
            holdSensors(stim, 12);
        end
        finishTest("reverse");

        // Ball caught from random states
        repeat (6) begin
            stim = sensorIn_t'(randomRange(0, 15));
            stim.ballCaught = 1'b0;
            holdSensors(stim, randomRange(1, 8));
            stim.ballCaught = 1'b1;
            sensors = stim;
            waitForDone(3);
            holdSensors('0, 2);
        end
        finishTest("ball caught");

        $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && uChecker.errorCount + tbErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
